//--- src/noc_router_pkg.sv
// Shared constants and flit format of the four-port router.
// Port count and VC count are fixed here; changing them needs matching
// index widths below, which are not derived automatically.

package noc_router_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int unsigned NumPorts     = 4;
  localparam int unsigned NumVc        = 2;
  localparam int unsigned VcIdxWidth   = 1;
  localparam int unsigned PortIdxWidth = 2;
  localparam int unsigned DataWidth    = 16;

  //////////////////////////////
  // Flit format
  //////////////////////////////

  // Port numbering, also the index of each port in the router arrays
  typedef enum logic [PortIdxWidth-1:0] {
    North = 2'd0,
    East  = 2'd1,
    South = 2'd2,
    West  = 2'd3
  } port_dir_e;

  // Head flits carry the output port in the upper bits,
  // all other flits use the whole body as payload
  typedef union packed {
    struct packed {
      port_dir_e                         dst;
      logic [DataWidth-PortIdxWidth-1:0] tag;
    } head;
    logic [DataWidth-1:0] data;
  } flit_body_u;

  // A single-flit packet sets both head and last
  typedef struct packed {
    logic                  head;
    logic                  last;
    logic [VcIdxWidth-1:0] vc;
    flit_body_u            body;
  } flit_t;

endpackage

//--- src/vc_input_port.sv
// One input port with a circular flit FIFO per virtual channel.
// The upstream sender must hold a credit for a VC before it sends on it.
// A flit that still arrives at a full FIFO is dropped.
// VcDepth may be any value of 1 or more.

module vc_input_port #(
  parameter int unsigned VcDepth = 2
) (
  input  logic                                             clk_i,
  input  logic                                             arst_n_i,
  input  logic                                             flit_valid_i,
  input  noc_router_pkg::flit_t                            flit_i,
  input  logic                                             pop_i,
  input  logic [noc_router_pkg::VcIdxWidth-1:0]            pop_vc_i,
  output logic [noc_router_pkg::NumVc-1:0]                 vc_nonempty_o,
  output noc_router_pkg::flit_t [noc_router_pkg::NumVc-1:0] vc_head_o,
  output logic                                             credit_valid_o,
  output logic [noc_router_pkg::VcIdxWidth-1:0]            credit_id_o
);
  import noc_router_pkg::*;

  localparam int unsigned PtrWidth = (VcDepth > 1) ? $clog2(VcDepth) : 1;
  localparam int unsigned CntWidth = $clog2(VcDepth + 1);

  logic [NumVc-1:0] vc_full;
  logic [NumVc-1:0] vc_rd;

  // Pointer increment with wrap at the FIFO depth
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(VcDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  //////////////////////////////
  // Per-VC FIFOs
  //////////////////////////////

  for (genvar v = 0; v < NumVc; v++) begin : gen_vc
    flit_t               mem [VcDepth];
    logic [PtrWidth-1:0] wr_ptr_q;
    logic [PtrWidth-1:0] rd_ptr_q;
    logic [CntWidth-1:0] count_q;
    logic                wr_en;

    assign vc_full[v]       = (count_q == CntWidth'(VcDepth));
    assign vc_nonempty_o[v] = (count_q != '0);
    assign vc_head_o[v]     = mem[rd_ptr_q];

    // Each flit goes to the FIFO of the VC it names
    assign wr_en    = flit_valid_i && (flit_i.vc == VcIdxWidth'(v)) && !vc_full[v];
    assign vc_rd[v] = pop_i && (pop_vc_i == VcIdxWidth'(v)) && vc_nonempty_o[v];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (wr_en) begin
          wr_ptr_q <= next_ptr(wr_ptr_q);
        end
        if (vc_rd[v]) begin
          rd_ptr_q <= next_ptr(rd_ptr_q);
        end
        count_q <= count_q + CntWidth'(wr_en) - CntWidth'(vc_rd[v]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (wr_en) begin
        mem[wr_ptr_q] <= flit_i;
      end
    end
  end

  //////////////////////////////
  // Credit return
  //////////////////////////////

  // One credit per flit that left a FIFO, one cycle after the pop
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_valid_o <= 1'b0;
    end else begin
      credit_valid_o <= |vc_rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|vc_rd) begin
      credit_id_o <= pop_vc_i;
    end
  end

endmodule

//--- src/out_credit_tracker.sv
// Credit counters for the VC buffers of the downstream neighbour.
// A VC starts with VcDepth credits; counts saturate at 0 and VcDepth.

module out_credit_tracker #(
  parameter int unsigned VcDepth = 2
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                                  consume_i,
  input  logic [noc_router_pkg::VcIdxWidth-1:0] consume_vc_i,
  input  logic                                  credit_valid_i,
  input  logic [noc_router_pkg::VcIdxWidth-1:0] credit_id_i,
  output logic [noc_router_pkg::NumVc-1:0]      vc_has_credit_o
);
  import noc_router_pkg::*;

  localparam int unsigned CntWidth = $clog2(VcDepth + 1);

  for (genvar v = 0; v < NumVc; v++) begin : gen_vc
    logic [CntWidth-1:0] count_q;
    logic                take;
    logic                give;

    assign take = consume_i && (consume_vc_i == VcIdxWidth'(v));
    assign give = credit_valid_i && (credit_id_i == VcIdxWidth'(v));

    // A sent flit and a returned credit in one cycle cancel out
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        count_q <= CntWidth'(VcDepth);
      end else if (give && !take) begin
        if (count_q != CntWidth'(VcDepth)) begin
          count_q <= count_q + 1'b1;
        end
      end else if (take && !give) begin
        if (count_q != '0) begin
          count_q <= count_q - 1'b1;
        end
      end
    end

    assign vc_has_credit_o[v] = (count_q != '0);
  end

endmodule

//--- src/switch_allocator.sv
// Switch allocation for all inputs and outputs in one combinational step.
// Grants are valid in the cycle after a flit enters its FIFO; the pop and
// the crossbar register both act at the following edge.
// An input serves one VC and an output one input until the packet's last
// flit is granted, so packets never interleave on an output.

module switch_allocator (
  input  logic                                                   clk_i,
  input  logic                                                   arst_n_i,
  input  logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0] vc_nonempty_i,
  input  noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0]
                                                                 vc_head_i,
  input  logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0] vc_has_credit_i,
  output logic [noc_router_pkg::NumPorts-1:0]                    pop_o,
  output logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::VcIdxWidth-1:0] pop_vc_o,
  output logic [noc_router_pkg::NumPorts-1:0]                    out_valid_o,
  output logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::PortIdxWidth-1:0] out_sel_o,
  output logic [noc_router_pkg::NumPorts-1:0]                    consume_o,
  output logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::VcIdxWidth-1:0] consume_vc_o
);
  import noc_router_pkg::*;

  // Input side state and requests
  logic [NumPorts-1:0]                   in_lock_q;
  logic [NumPorts-1:0][VcIdxWidth-1:0]   in_lock_vc_q;
  logic [NumPorts-1:0][PortIdxWidth-1:0] in_lock_out_q;
  logic [NumPorts-1:0][VcIdxWidth-1:0]   in_rr_q;
  logic [NumPorts-1:0][VcIdxWidth-1:0]   in_sel_vc;
  flit_t [NumPorts-1:0]                  in_flit;
  logic [NumPorts-1:0]                   in_req;
  logic [NumPorts-1:0][PortIdxWidth-1:0] in_out;

  // Output side state and requests, out_req is indexed [output][input]
  logic [NumPorts-1:0]                   out_lock_q;
  logic [NumPorts-1:0][PortIdxWidth-1:0] out_lock_in_q;
  logic [NumPorts-1:0][PortIdxWidth-1:0] out_rr_q;
  logic [NumPorts-1:0][NumPorts-1:0]     out_req;

  // Round robin pick among the first n request bits, ptr has top priority
  function automatic int unsigned rr_pick(input logic [NumPorts-1:0] req,
                                          input int unsigned n,
                                          input int unsigned ptr);
    int unsigned idx;
    rr_pick = ptr % n;
    for (int unsigned k = n; k > 0; k--) begin
      idx = (ptr + k - 1) % n;
      if (req[idx]) begin
        rr_pick = idx;
      end
    end
  endfunction

  //////////////////////////////
  // Input VC arbitration
  //////////////////////////////

  always_comb begin
    for (int i = 0; i < NumPorts; i++) begin
      if (in_lock_q[i]) begin
        in_sel_vc[i] = in_lock_vc_q[i];
      end else begin
        in_sel_vc[i] = VcIdxWidth'(rr_pick({{(NumPorts - NumVc){1'b0}}, vc_nonempty_i[i]},
                                           NumVc, in_rr_q[i]));
      end
      in_flit[i] = vc_head_i[i][in_sel_vc[i]];
      in_req[i]  = vc_nonempty_i[i][in_sel_vc[i]];
      // Body flits follow the output their head flit opened
      in_out[i]  = in_lock_q[i] ? in_lock_out_q[i] : in_flit[i].body.head.dst;
    end
  end

  //////////////////////////////
  // Output arbitration
  //////////////////////////////

  always_comb begin
    out_req = '0;
    pop_o   = '0;
    for (int o = 0; o < NumPorts; o++) begin
      for (int i = 0; i < NumPorts; i++) begin
        out_req[o][i] = in_req[i] && (in_out[i] == PortIdxWidth'(o)) &&
                        vc_has_credit_i[o][in_sel_vc[i]];
      end
      if (out_lock_q[o]) begin
        out_sel_o[o]   = out_lock_in_q[o];
        out_valid_o[o] = out_req[o][out_lock_in_q[o]];
      end else begin
        out_sel_o[o]   = PortIdxWidth'(rr_pick(out_req[o], NumPorts, out_rr_q[o]));
        out_valid_o[o] = |out_req[o];
      end
      consume_vc_o[o] = in_sel_vc[out_sel_o[o]];
      if (out_valid_o[o]) begin
        pop_o[out_sel_o[o]] = 1'b1;
      end
    end
  end

  assign consume_o = out_valid_o;
  assign pop_vc_o  = in_sel_vc;

  //////////////////////////////
  // Wormhole locks
  //////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_lock_q     <= '0;
      in_lock_vc_q  <= '0;
      in_lock_out_q <= '0;
      in_rr_q       <= '0;
      out_lock_q    <= '0;
      out_lock_in_q <= '0;
      out_rr_q      <= '0;
    end else begin
      for (int i = 0; i < NumPorts; i++) begin
        if (pop_o[i] && in_flit[i].last) begin
          in_lock_q[i] <= 1'b0;
          in_rr_q[i]   <= in_sel_vc[i] + 1'b1;
        end else if (pop_o[i]) begin
          in_lock_q[i]     <= 1'b1;
          in_lock_vc_q[i]  <= in_sel_vc[i];
          in_lock_out_q[i] <= in_out[i];
        end
      end
      for (int o = 0; o < NumPorts; o++) begin
        if (out_valid_o[o] && in_flit[out_sel_o[o]].last) begin
          out_lock_q[o] <= 1'b0;
          out_rr_q[o]   <= out_sel_o[o] + 1'b1;
        end else if (out_valid_o[o]) begin
          out_lock_q[o]    <= 1'b1;
          out_lock_in_q[o] <= out_sel_o[o];
        end
      end
    end
  end

endmodule

//--- src/crossbar_switch.sv
// Registered crossbar from the granted FIFO heads to the output ports.
// The flit register keeps its last value while no flit is granted, so
// data_o is meaningful only while data_valid_o is high.

module crossbar_switch (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0][noc_router_pkg::NumVc-1:0]
                                                      vc_head_i,
  input  logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::VcIdxWidth-1:0] pop_vc_i,
  input  logic [noc_router_pkg::NumPorts-1:0]         out_valid_i,
  input  logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::PortIdxWidth-1:0] out_sel_i,
  output logic [noc_router_pkg::NumPorts-1:0]         data_valid_o,
  output noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0] data_o
);
  import noc_router_pkg::*;

  flit_t [NumPorts-1:0] sel_flit;

  //////////////////////////////
  // Switch traversal
  //////////////////////////////

  // Input port first, then the VC that port is serving
  always_comb begin
    for (int o = 0; o < NumPorts; o++) begin
      sel_flit[o] = vc_head_i[out_sel_i[o]][pop_vc_i[out_sel_i[o]]];
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_valid_o <= '0;
    end else begin
      data_valid_o <= out_valid_i;
    end
  end

  // Flits leave unchanged, including their VC field
  always_ff @(posedge clk_i) begin
    for (int o = 0; o < NumPorts; o++) begin
      if (out_valid_i[o]) begin
        data_o[o] <= sel_flit[o];
      end
    end
  end

endmodule

//--- src/noc_router.sv
// Four-port wormhole router, two VCs per port, credit flow control.
// Head flits carry their output port (source routing); flits keep their VC.
// Minimum latency is one cycle from the sampling edge to data_valid_o.
// Upstream senders start with VcDepth credits per VC.

module noc_router #(
  parameter int unsigned VcDepth = 2
) (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  logic [noc_router_pkg::NumPorts-1:0]            data_valid_i,
  input  logic [noc_router_pkg::NumPorts-1:0]            credit_valid_i,
  input  noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0] data_i,
  input  logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::VcIdxWidth-1:0] credit_id_i,
  output logic [noc_router_pkg::NumPorts-1:0]            data_valid_o,
  output logic [noc_router_pkg::NumPorts-1:0]            credit_valid_o,
  output noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0] data_o,
  output logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::VcIdxWidth-1:0] credit_id_o
);
  import noc_router_pkg::*;

  logic [NumPorts-1:0][NumVc-1:0]        vc_nonempty;
  flit_t [NumPorts-1:0][NumVc-1:0]       vc_head;
  logic [NumPorts-1:0][NumVc-1:0]        vc_has_credit;
  logic [NumPorts-1:0]                   pop;
  logic [NumPorts-1:0][VcIdxWidth-1:0]   pop_vc;
  logic [NumPorts-1:0]                   out_valid;
  logic [NumPorts-1:0][PortIdxWidth-1:0] out_sel;
  logic [NumPorts-1:0]                   consume;
  logic [NumPorts-1:0][VcIdxWidth-1:0]   consume_vc;

  //////////////////////////////
  // Per-port blocks
  //////////////////////////////

  for (genvar p = 0; p < NumPorts; p++) begin : gen_port
    vc_input_port #(
      .VcDepth ( VcDepth )
    ) u_in (
      .clk_i          ( clk_i             ),
      .arst_n_i       ( arst_n_i          ),
      .flit_valid_i   ( data_valid_i[p]   ),
      .flit_i         ( data_i[p]         ),
      .pop_i          ( pop[p]            ),
      .pop_vc_i       ( pop_vc[p]         ),
      .vc_nonempty_o  ( vc_nonempty[p]    ),
      .vc_head_o      ( vc_head[p]        ),
      .credit_valid_o ( credit_valid_o[p] ),
      .credit_id_o    ( credit_id_o[p]    )
    );

    out_credit_tracker #(
      .VcDepth ( VcDepth )
    ) u_credit (
      .clk_i           ( clk_i             ),
      .arst_n_i        ( arst_n_i          ),
      .consume_i       ( consume[p]        ),
      .consume_vc_i    ( consume_vc[p]     ),
      .credit_valid_i  ( credit_valid_i[p] ),
      .credit_id_i     ( credit_id_i[p]    ),
      .vc_has_credit_o ( vc_has_credit[p]  )
    );
  end

  //////////////////////////////
  // Allocation and switching
  //////////////////////////////

  switch_allocator u_alloc (
    .clk_i           ( clk_i         ),
    .arst_n_i        ( arst_n_i      ),
    .vc_nonempty_i   ( vc_nonempty   ),
    .vc_head_i       ( vc_head       ),
    .vc_has_credit_i ( vc_has_credit ),
    .pop_o           ( pop           ),
    .pop_vc_o        ( pop_vc        ),
    .out_valid_o     ( out_valid     ),
    .out_sel_o       ( out_sel       ),
    .consume_o       ( consume       ),
    .consume_vc_o    ( consume_vc    )
  );

  crossbar_switch u_xbar (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .vc_head_i    ( vc_head      ),
    .pop_vc_i     ( pop_vc       ),
    .out_valid_i  ( out_valid    ),
    .out_sel_i    ( out_sel      ),
    .data_valid_o ( data_valid_o ),
    .data_o       ( data_o       )
  );

endmodule

//--- tb/tb_clock_gen.sv
// Free-running 8 ns clock for the testbench.
// Reset is held for the first two cycles and released on a falling edge.

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    #16;
    arst_n_o = 1'b1;
  end

  always #4 clk_o = ~clk_o;

endmodule

//--- tb/noc_router_assert.sv
// Protocol assertions bound into the router top level.
// FIFO occupancy is rebuilt here from the input strobes and the pops.

module noc_router_assert #(
  parameter int unsigned VcDepth = 2
) (
  input logic                                                clk_i,
  input logic                                                arst_n_i,
  input logic [noc_router_pkg::NumPorts-1:0]                 in_valid_i,
  input noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0] in_flit_i,
  input logic [noc_router_pkg::NumPorts-1:0]                 pop_i,
  input logic [noc_router_pkg::NumPorts-1:0][noc_router_pkg::VcIdxWidth-1:0] pop_vc_i,
  input logic [noc_router_pkg::NumPorts-1:0]                 out_valid_i,
  input noc_router_pkg::flit_t [noc_router_pkg::NumPorts-1:0] out_flit_i,
  input logic [noc_router_pkg::NumPorts-1:0]                 credit_pulse_i
);
  timeunit 1ns;
  timeprecision 100ps;
  import noc_router_pkg::*;

  int unsigned                         occ_q [NumPorts][NumVc];
  logic [NumPorts-1:0]                 in_pkt_q;
  logic [NumPorts-1:0][VcIdxWidth-1:0] pkt_vc_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVc; v++) begin
          occ_q[p][v] <= 0;
        end
      end
      in_pkt_q <= '0;
      pkt_vc_q <= '0;
    end else begin
      for (int p = 0; p < NumPorts; p++) begin
        for (int v = 0; v < NumVc; v++) begin
          occ_q[p][v] <= occ_q[p][v]
                         + 32'(in_valid_i[p] && in_flit_i[p].vc == VcIdxWidth'(v))
                         - 32'(pop_i[p] && pop_vc_i[p] == VcIdxWidth'(v));
        end
        // Open packet per output, closed by its last flit
        if (out_valid_i[p]) begin
          in_pkt_q[p] <= !out_flit_i[p].last;
          pkt_vc_q[p] <= out_flit_i[p].vc;
        end
      end
    end
  end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_chk
    a_no_full_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      in_valid_i[p] |-> occ_q[p][in_flit_i[p].vc] < VcDepth)
      else $error("flit written into a full VC FIFO on port %0d", p);

    // Head flit only when no packet is open, same VC until the last flit
    a_no_interleave: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_i[p] |-> (out_flit_i[p].head == !in_pkt_q[p]) &&
                         (!in_pkt_q[p] || out_flit_i[p].vc == pkt_vc_q[p]))
      else $error("packets interleaved on output %0d", p);
  end

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> (out_valid_i == '0) && (credit_pulse_i == '0))
    else $error("router outputs active during reset");

endmodule

bind noc_router noc_router_assert #(
  .VcDepth ( VcDepth )
) u_assert (
  .clk_i          ( clk_i          ),
  .arst_n_i       ( arst_n_i       ),
  .in_valid_i     ( data_valid_i   ),
  .in_flit_i      ( data_i         ),
  .pop_i          ( pop            ),
  .pop_vc_i       ( pop_vc         ),
  .out_valid_i    ( data_valid_o   ),
  .out_flit_i     ( data_o         ),
  .credit_pulse_i ( credit_valid_o )
);

//--- tb/noc_router_tb.sv
// Random wormhole traffic on all four ports with a fixed seed.
// Expected flits are queued per output, VC and source port.
// Downstream credits return after 0 to 3 cycles and are withheld once.

module noc_router_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import noc_router_pkg::*;

  localparam int VcDepth   = 2;
  localparam int NumPkts   = 40;
  localparam int HoldStart = 100;
  localparam int HoldLen   = 60;

  logic                                clk;
  logic                                arst_n;
  logic [NumPorts-1:0]                 data_valid_i;
  logic [NumPorts-1:0]                 credit_valid_i;
  flit_t [NumPorts-1:0]                data_i;
  logic [NumPorts-1:0][VcIdxWidth-1:0] credit_id_i;
  logic [NumPorts-1:0]                 data_valid_o;
  logic [NumPorts-1:0]                 credit_valid_o;
  flit_t [NumPorts-1:0]                data_o;
  logic [NumPorts-1:0][VcIdxWidth-1:0] credit_id_o;

  int    seed = 32'h381e;
  int    cyc;
  int    limit;
  int    total_flits;
  int    recv_flits;
  int    first_send;
  flit_t send_q [NumPorts][$];
  flit_t exp_q [NumPorts][NumVc][NumPorts][$];
  int    ret_q [NumPorts][$];
  int    last_due [NumPorts];
  int    cur_src [NumPorts][NumVc];
  int    up_credit [NumPorts][NumVc];
  int    in_flight [NumPorts][NumVc];
  int    sent_cnt [NumPorts][NumVc];
  int    ret_cnt [NumPorts][NumVc];
  logic [VcIdxWidth-1:0] pkt_vc [NumPorts][NumPkts];

  tb_clock_gen u_clk (
    .clk_o    ( clk    ),
    .arst_n_o ( arst_n )
  );

  noc_router #(
    .VcDepth ( VcDepth )
  ) uut (
    .clk_i          ( clk            ),
    .arst_n_i       ( arst_n         ),
    .data_valid_i   ( data_valid_i   ),
    .credit_valid_i ( credit_valid_i ),
    .data_i         ( data_i         ),
    .credit_id_i    ( credit_id_i    ),
    .data_valid_o   ( data_valid_o   ),
    .credit_valid_o ( credit_valid_o ),
    .data_o         ( data_o         ),
    .credit_id_o    ( credit_id_o    )
  );

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_port(input string name, input port_dir_e got, input port_dir_e exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t %s got %s expected %s", $time, name,
                         got.name(), exp.name()));
    end
  endtask

  task automatic check_vc(input string name, input logic [VcIdxWidth-1:0] got,
                          input logic [VcIdxWidth-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      fail_run($sformatf("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  // Tag holds source, VC and sequence number; port 0 opens with one flit
  task automatic make_packets(input int src);
    int                    len;
    int                    dst;
    logic [VcIdxWidth-1:0] vc;
    flit_t                 f;
    for (int n = 0; n < NumPkts; n++) begin
      len = (src == 0 && n == 0) ? 1 : 1 + int'($unsigned($random(seed)) % 4);
      dst = (src + 1 + int'($unsigned($random(seed)) % 3)) % NumPorts;
      vc  = 1'($random(seed));
      pkt_vc[src][n] = vc;
      for (int k = 0; k < len; k++) begin
        f.head = (k == 0);
        f.last = (k == len - 1);
        f.vc   = vc;
        if (k == 0) begin
          f.body.head.dst = port_dir_e'(dst);
          f.body.head.tag = {2'(src), vc, 11'(n)};
        end else begin
          f.body.data = 16'($random(seed));
        end
        send_q[src].push_back(f);
        exp_q[dst][vc][src].push_back(f);
        total_flits++;
      end
    end
  endtask

  task automatic take_flit(input int o);
    flit_t got;
    int    v;
    int    src;
    got = data_o[o];
    v   = int'(got.vc);
    if (in_flight[o][v] >= VcDepth) begin
      fail_run($sformatf("Output %0d sent on VC %0d without a downstream credit", o, v));
    end
    in_flight[o][v]++;
    if (got.head) begin
      cur_src[o][v] = int'(got.body.head.tag[13:12]);
      check_port($sformatf("data_o[%0d].dst", o), got.body.head.dst, port_dir_e'(o));
      check_vc($sformatf("data_o[%0d].vc", o), got.vc,
               pkt_vc[got.body.head.tag[13:12]][got.body.head.tag[10:0]]);
    end
    src = cur_src[o][v];
    if (got.head && src == 0 && got.body.head.tag[10:0] == '0) begin
      check_count($sformatf("data_valid_o[%0d] latency", o), cyc - first_send, 2);
    end
    if (exp_q[o][v][src].size() == 0) begin
      fail_run($sformatf("Output %0d delivered a flit that was never sent", o));
    end
    check_flit($sformatf("data_o[%0d]", o), got, exp_q[o][v][src].pop_front());
    recv_flits++;
  endtask

  // Samples outputs first, then drives the inputs for the next edge
  task automatic step_cycle();
    int   due;
    logic holding;
    cyc++;
    if (cyc > limit) begin
      fail_run("Timeout: not every flit was delivered before the cycle limit");
    end
    for (int p = 0; p < NumPorts; p++) begin
      if (credit_valid_o[p]) begin
        up_credit[p][credit_id_o[p]]++;
        ret_cnt[p][credit_id_o[p]]++;
        if (up_credit[p][credit_id_o[p]] > VcDepth) begin
          fail_run($sformatf("Input %0d returned more credits than flits sent", p));
        end
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      if (data_valid_o[o]) begin
        take_flit(o);
        due = cyc + int'($unsigned($random(seed)) % 4);
        if (due <= last_due[o]) begin
          due = last_due[o] + 1;
        end
        last_due[o] = due;
        ret_q[o].push_back(due * 2 + int'(data_o[o].vc));
      end
    end
    holding = (cyc >= HoldStart) && (cyc < HoldStart + HoldLen);
    for (int o = 0; o < NumPorts; o++) begin
      credit_valid_i[o] = 1'b0;
      if (!holding && ret_q[o].size() > 0 && ret_q[o][0] / 2 <= cyc) begin
        credit_id_i[o]    = 1'(ret_q[o][0] % 2);
        credit_valid_i[o] = 1'b1;
        in_flight[o][ret_q[o][0] % 2]--;
        void'(ret_q[o].pop_front());
      end
    end
    // Other ports start late so the first packet meets an idle router
    for (int p = 0; p < NumPorts; p++) begin
      data_valid_i[p] = 1'b0;
      if (send_q[p].size() > 0 && (p == 0 || cyc > 3) &&
          up_credit[p][send_q[p][0].vc] > 0) begin
        if (p == 0 && first_send < 0) begin
          first_send = cyc;
        end
        data_i[p]       = send_q[p].pop_front();
        data_valid_i[p] = 1'b1;
        up_credit[p][data_i[p].vc]--;
        sent_cnt[p][data_i[p].vc]++;
      end
    end
  endtask

  initial begin
    data_valid_i   = '0;
    data_i         = '0;
    credit_valid_i = '0;
    credit_id_i    = '0;
    first_send     = -1;
    for (int p = 0; p < NumPorts; p++) begin
      last_due[p] = -1;
      for (int v = 0; v < NumVc; v++) begin
        up_credit[p][v] = VcDepth;
      end
      make_packets(p);
    end
    limit = 20 * total_flits + 200;
    @(negedge clk);
    if (data_valid_o !== '0 || credit_valid_o !== '0) begin
      fail_run("Router outputs were active during reset");
    end
    @(negedge clk);
    while (recv_flits < total_flits) begin
      @(negedge clk);
      step_cycle();
    end
    for (int p = 0; p < NumPorts; p++) begin
      for (int v = 0; v < NumVc; v++) begin
        check_count($sformatf("credit_valid_o[%0d] count on VC %0d", p, v),
                    ret_cnt[p][v], sent_cnt[p][v]);
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

//--- compile.f
src/noc_router_pkg.sv
src/vc_input_port.sv
src/out_credit_tracker.sv
src/switch_allocator.sv
src/crossbar_switch.sv
src/noc_router.sv
tb/tb_clock_gen.sv
tb/noc_router_assert.sv
tb/noc_router_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the router testbench with Verilator and runs it.
# The script exits non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module noc_router_tb -o sim_noc_router; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_noc_router; then
  echo "Simulation failed"
  exit 1
fi

exit 0
